/* hw/exec_consts.svh */
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Data and address width
`define EXEC_XLEN 32

// RV32I major opcodes
`define EXEC_OPC_OP      7'b0110011
`define EXEC_OPC_OP_IMM  7'b0010011
`define EXEC_OPC_LUI     7'b0110111
`define EXEC_OPC_AUIPC   7'b0010111
`define EXEC_OPC_JAL     7'b1101111
`define EXEC_OPC_JALR    7'b1100111
`define EXEC_OPC_BRANCH  7'b1100011
`define EXEC_OPC_LOAD    7'b0000011
`define EXEC_OPC_STORE   7'b0100011

// Data memory commands
`define EXEC_MEM_CMD_NONE   2'd0
`define EXEC_MEM_CMD_LOAD   2'd1
`define EXEC_MEM_CMD_STORE  2'd2

// Data memory responses
`define EXEC_MEM_RESP_IDLE        3'd0
`define EXEC_MEM_RESP_DONE        3'd1
`define EXEC_MEM_RESP_MISALIGNED  3'd2
`define EXEC_MEM_RESP_ACCESS      3'd3
`define EXEC_MEM_RESP_PAGE        3'd4

// Exception cause codes
`define EXEC_CAUSE_ILLEGAL           5'd2
`define EXEC_CAUSE_LOAD_MISALIGNED   5'd4
`define EXEC_CAUSE_LOAD_ACCESS       5'd5
`define EXEC_CAUSE_STORE_MISALIGNED  5'd6
`define EXEC_CAUSE_STORE_ACCESS      5'd7
`define EXEC_CAUSE_LOAD_PAGE         5'd13
`define EXEC_CAUSE_STORE_PAGE        5'd15

`endif

/* hw/exec_pkg.sv */
`default_nettype none

`include "exec_consts.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0] word_t;

    // One instruction word seen through each RV32I format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_u;

    typedef enum logic [3:0] {
        CL_ALU,
        CL_LUI,
        CL_AUIPC,
        CL_JAL,
        CL_JALR,
        CL_BRANCH,
        CL_LOAD,
        CL_STORE,
        CL_ILLEGAL
    } insn_class_e;

    typedef enum logic [1:0] {
        MEM_NONE  = `EXEC_MEM_CMD_NONE,
        MEM_LOAD  = `EXEC_MEM_CMD_LOAD,
        MEM_STORE = `EXEC_MEM_CMD_STORE
    } mem_cmd_e;

    typedef enum logic [2:0] {
        RESP_IDLE       = `EXEC_MEM_RESP_IDLE,
        RESP_DONE       = `EXEC_MEM_RESP_DONE,
        RESP_MISALIGNED = `EXEC_MEM_RESP_MISALIGNED,
        RESP_ACCESS     = `EXEC_MEM_RESP_ACCESS,
        RESP_PAGE       = `EXEC_MEM_RESP_PAGE
    } mem_resp_e;

    typedef struct packed {
        instr_u instr;
        word_t  pc;
    } fetch_in_t;

    typedef struct packed {
        logic       ready;
        logic       exc_start;
        logic [4:0] exc_cause;
        logic       branch_taken;
        word_t      branch_target;
    } fetch_out_t;

    typedef struct packed {
        mem_cmd_e   cmd;
        word_t      addr;
        logic [2:0] load_type;
        logic [1:0] store_type;
        word_t      store_data;
    } mem_req_t;

    typedef struct packed {
        mem_resp_e resp;
        word_t     load_data;
    } mem_rsp_t;

    // Decoder result with an OP-IMM flag
    typedef struct packed {
        insn_class_e cls;
        logic        is_imm;
        logic [2:0]  funct3;
        logic        funct7_b5;
        logic [4:0]  shamt;
        word_t       imm;
    } dec_t;

endpackage

`default_nettype wire

/* hw/exec_decoder.sv */
`default_nettype none

`include "exec_consts.svh"

module exec_decoder import exec_pkg::*; (
    input  instr_u     instr,
    output dec_t       dec,
    output logic [4:0] rs1_addr,
    output logic [4:0] rs2_addr,
    output logic [4:0] rd_addr
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic       is_shift;
    logic       funct7_bad;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode   = instr.r.opcode;
    assign funct7   = instr.r.funct7;
    assign rs1_addr = instr.r.rs1;
    assign rs2_addr = instr.r.rs2;
    assign rd_addr  = instr.r.rd;

    // Only bit 5 of funct7 may be set in RV32I
    assign funct7_bad = (funct7 & 7'b1011111) != 7'd0;
    assign is_shift   = (instr.r.funct3 == 3'd1) || (instr.r.funct3 == 3'd5);

    assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign imm_u = {instr.u.imm, 12'h000};
    assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                    instr.j.imm_11, instr.j.imm_10_1, 1'b0};

    always_comb begin
        dec.cls       = CL_ILLEGAL;
        dec.is_imm    = 1'b0;
        dec.funct3    = instr.r.funct3;
        dec.funct7_b5 = funct7[5];
        dec.shamt     = instr.r.rs2;
        dec.imm       = '0;
        case (opcode)
            `EXEC_OPC_OP: begin
                dec.cls = funct7_bad ? CL_ILLEGAL : CL_ALU;
            end
            `EXEC_OPC_OP_IMM: begin
                // Upper bits only encode the shift type for shifts
                dec.cls    = (is_shift && funct7_bad) ? CL_ILLEGAL : CL_ALU;
                dec.is_imm = 1'b1;
                dec.imm    = imm_i;
            end
            `EXEC_OPC_LUI: begin
                dec.cls = CL_LUI;
                dec.imm = imm_u;
            end
            `EXEC_OPC_AUIPC: begin
                dec.cls = CL_AUIPC;
                dec.imm = imm_u;
            end
            `EXEC_OPC_JAL: begin
                dec.cls = CL_JAL;
                dec.imm = imm_j;
            end
            `EXEC_OPC_JALR: begin
                dec.cls = (instr.i.funct3 == 3'd0) ? CL_JALR : CL_ILLEGAL;
                dec.imm = imm_i;
            end
            `EXEC_OPC_BRANCH: begin
                dec.cls = CL_BRANCH;
                dec.imm = imm_b;
            end
            `EXEC_OPC_LOAD: begin
                dec.cls = CL_LOAD;
                dec.imm = imm_i;
            end
            `EXEC_OPC_STORE: begin
                // Store funct3 values 4 to 7 are illegal
                dec.cls = instr.s.funct3[2] ? CL_ILLEGAL : CL_STORE;
                dec.imm = imm_s;
            end
            default: begin
                dec.cls = CL_ILLEGAL;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/exec_alu.sv */
`default_nettype none

module exec_alu import exec_pkg::*; (
    input  logic       is_imm,
    input  logic [2:0] funct3,
    input  logic       funct7_b5,
    input  logic [4:0] shamt,
    input  word_t      rs1,
    input  word_t      op_b,
    output word_t      result,
    output logic       illegal
);

    logic [4:0] sh;
    word_t      sra_res;

    // Register shifts take the amount from rs2
    assign sh      = is_imm ? shamt : op_b[4:0];
    assign sra_res = $signed(rs1) >>> sh;

    // Alternate form allowed for SUB and SRA/SRAI only
    always_comb begin
        if (is_imm) begin
            illegal = funct7_b5 && (funct3 == 3'd1);
        end else begin
            illegal = funct7_b5 && (funct3 != 3'd0) && (funct3 != 3'd5);
        end
    end

    always_comb begin
        result = '0;
        case (funct3)
            3'd0: begin
                // For ADDI bit 30 is part of the immediate
                if (funct7_b5 && !is_imm) begin
                    result = rs1 - op_b;
                end else begin
                    result = rs1 + op_b;
                end
            end
            3'd1: result = rs1 << sh;
            3'd2: result[0] = $signed(rs1) < $signed(op_b);
            3'd3: result[0] = rs1 < op_b;
            3'd4: result = rs1 ^ op_b;
            3'd5: result = funct7_b5 ? sra_res : (rs1 >> sh);
            3'd6: result = rs1 | op_b;
            default: result = rs1 & op_b;
        endcase
    end

endmodule

`default_nettype wire

/* hw/exec_branch_cond.sv */
`default_nettype none

module exec_branch_cond import exec_pkg::*; (
    input  logic [2:0] funct3,
    input  word_t      rs1,
    input  word_t      rs2,
    output logic       taken,
    output logic       illegal
);

    always_comb begin
        taken   = 1'b0;
        illegal = 1'b0;
        case (funct3)
            3'd0: taken = rs1 == rs2;
            3'd1: taken = rs1 != rs2;
            3'd4: taken = $signed(rs1) < $signed(rs2);
            3'd5: taken = $signed(rs1) >= $signed(rs2);
            3'd6: taken = rs1 < rs2;
            3'd7: taken = rs1 >= rs2;
            // funct3 2 and 3 are unused
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* hw/exec_mem_seq.sv */
`default_nettype none

`include "exec_consts.svh"

module exec_mem_seq import exec_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       is_load,
    input  logic       is_store,
    input  word_t      addr,
    input  logic [2:0] funct3,
    input  word_t      store_data,
    output mem_req_t   mem_req,
    input  mem_rsp_t   mem_rsp,
    output logic       done,
    output logic       fault,
    output logic [4:0] fault_cause
);

    logic       issued;
    logic       fault_pending;
    logic [4:0] pending_cause;
    logic       rsp_valid;
    logic       rsp_fault;
    logic [4:0] rsp_cause;

    // Responses only count once the command has been seen for an edge
    assign rsp_valid = issued && (mem_rsp.resp != RESP_IDLE);
    assign rsp_fault = rsp_valid && (mem_rsp.resp != RESP_DONE);

    always_comb begin
        mem_req.cmd        = MEM_NONE;
        mem_req.addr       = addr;
        mem_req.load_type  = funct3;
        mem_req.store_type = funct3[1:0];
        mem_req.store_data = store_data;
        if (!fault_pending && !rsp_valid) begin
            if (is_load) begin
                mem_req.cmd = MEM_LOAD;
            end else if (is_store) begin
                mem_req.cmd = MEM_STORE;
            end
        end
    end

    always_comb begin
        case (mem_rsp.resp)
            RESP_MISALIGNED: begin
                rsp_cause = is_load ? `EXEC_CAUSE_LOAD_MISALIGNED
                                    : `EXEC_CAUSE_STORE_MISALIGNED;
            end
            RESP_PAGE: rsp_cause = is_load ? `EXEC_CAUSE_LOAD_PAGE : `EXEC_CAUSE_STORE_PAGE;
            default:   rsp_cause = is_load ? `EXEC_CAUSE_LOAD_ACCESS : `EXEC_CAUSE_STORE_ACCESS;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issued        <= 1'b0;
            fault_pending <= 1'b0;
        end else begin
            // Pending lasts one cycle and issued is already clear by then
            fault_pending <= rsp_fault;
            if (rsp_valid) begin
                issued <= 1'b0;
            end else if (mem_req.cmd != MEM_NONE) begin
                issued <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_fault) begin
            pending_cause <= rsp_cause;
        end
    end

    assign done        = rsp_valid && (mem_rsp.resp == RESP_DONE);
    assign fault       = fault_pending;
    assign fault_cause = pending_cause;

endmodule

`default_nettype wire

/* hw/exec_stage.sv */
`default_nettype none

`include "exec_consts.svh"

module exec_stage import exec_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  fetch_in_t  fetch_in,
    output fetch_out_t fetch_out,
    output mem_req_t   mem_req,
    input  mem_rsp_t   mem_rsp,
    output logic [4:0] rs1_addr,
    output logic [4:0] rs2_addr,
    output logic [4:0] rd_addr,
    input  word_t      rs1_data,
    input  word_t      rs2_data,
    output word_t      rd_wdata,
    output logic       rd_write
);

    dec_t       dec;
    word_t      op_b;
    word_t      alu_result;
    word_t      rs1_plus_imm;
    word_t      pc_plus_imm;
    word_t      pc_plus_4;
    logic       alu_illegal;
    logic       br_taken;
    logic       br_illegal;
    logic       seq_done;
    logic       seq_fault;
    logic [4:0] seq_cause;
    logic       illegal;
    logic       wr_en;

    exec_decoder u_decoder (
        .instr    (fetch_in.instr),
        .dec      (dec),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr)
    );

    assign op_b = dec.is_imm ? dec.imm : rs2_data;

    exec_alu u_alu (
        .is_imm    (dec.is_imm),
        .funct3    (dec.funct3),
        .funct7_b5 (dec.funct7_b5),
        .shamt     (dec.shamt),
        .rs1       (rs1_data),
        .op_b      (op_b),
        .result    (alu_result),
        .illegal   (alu_illegal)
    );

    exec_branch_cond u_branch_cond (
        .funct3  (dec.funct3),
        .rs1     (rs1_data),
        .rs2     (rs2_data),
        .taken   (br_taken),
        .illegal (br_illegal)
    );

    // Load/store address and JALR target share one adder
    assign rs1_plus_imm = rs1_data + dec.imm;
    assign pc_plus_imm  = fetch_in.pc + dec.imm;
    assign pc_plus_4    = fetch_in.pc + 32'd4;

    exec_mem_seq u_mem_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .is_load     (dec.cls == CL_LOAD),
        .is_store    (dec.cls == CL_STORE),
        .addr        (rs1_plus_imm),
        .funct3      (dec.funct3),
        .store_data  (rs2_data),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .done        (seq_done),
        .fault       (seq_fault),
        .fault_cause (seq_cause)
    );

    always_comb begin
        illegal                 = 1'b0;
        wr_en                   = 1'b0;
        rd_wdata                = alu_result;
        fetch_out.ready         = 1'b1;
        fetch_out.branch_taken  = 1'b0;
        fetch_out.branch_target = pc_plus_imm;
        case (dec.cls)
            CL_ALU: begin
                wr_en   = 1'b1;
                illegal = alu_illegal;
            end
            CL_LUI: begin
                wr_en    = 1'b1;
                rd_wdata = dec.imm;
            end
            CL_AUIPC: begin
                wr_en    = 1'b1;
                rd_wdata = pc_plus_imm;
            end
            CL_JAL: begin
                wr_en                  = 1'b1;
                rd_wdata               = pc_plus_4;
                fetch_out.branch_taken = 1'b1;
            end
            CL_JALR: begin
                wr_en                   = 1'b1;
                rd_wdata                = pc_plus_4;
                fetch_out.branch_taken  = 1'b1;
                fetch_out.branch_target = rs1_plus_imm;
            end
            CL_BRANCH: begin
                illegal                = br_illegal;
                fetch_out.branch_taken = br_taken && !br_illegal;
            end
            CL_LOAD: begin
                wr_en           = seq_done;
                rd_wdata        = mem_rsp.load_data;
                fetch_out.ready = seq_done || seq_fault;
            end
            CL_STORE: begin
                fetch_out.ready = seq_done || seq_fault;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
        // Illegal encodings win over a memory fault
        fetch_out.exc_start = illegal || seq_fault;
        fetch_out.exc_cause = illegal ? `EXEC_CAUSE_ILLEGAL : seq_cause;
    end

    assign rd_write = wr_en && !illegal && (rd_addr != 5'd0);

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`default_nettype none

module tb_clock #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Synchronous reset released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/tb_exec_stage.sv */
`default_nettype none

`include "exec_consts.svh"

module tb_exec_stage import exec_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_INSTR          = 400;
    localparam int RESET_CYCLES     = 8;
    localparam int CYCLES_PER_INSTR = 6;
    localparam int MAX_CYCLES       = N_INSTR * CYCLES_PER_INSTR + RESET_CYCLES;

    // Expected DUT outputs for the current cycle
    typedef struct packed {
        logic       ready;
        logic       exc;
        logic [4:0] cause;
        logic       wr;
        word_t      wdata;
        logic       taken;
        logic       chk_target;
        word_t      target;
        mem_cmd_e   cmd;
        word_t      addr;
        logic [2:0] f3;
        word_t      sdata;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
    } expect_t;

    logic       clk;
    logic       rst_n;
    fetch_in_t  fetch_in;
    fetch_out_t fetch_out;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;
    logic [4:0] rs1_addr;
    logic [4:0] rs2_addr;
    logic [4:0] rd_addr;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      rd_wdata;
    logic       rd_write;

    expect_t    expected;
    logic       checking;
    word_t      rng_state = 32'h8576_6447;
    int         cycle_count = 0;

    tb_clock #(.RESET_CYCLES(RESET_CYCLES)) u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exec_stage dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_in  (fetch_in),
        .fetch_out (fetch_out),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rd_addr   (rd_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .rd_wdata  (rd_wdata),
        .rd_write  (rd_write)
    );

    function automatic word_t xorshift32(input word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic known_opcode(input logic [6:0] opc);
        return (opc == `EXEC_OPC_OP) || (opc == `EXEC_OPC_OP_IMM) || (opc == `EXEC_OPC_LUI)
            || (opc == `EXEC_OPC_AUIPC) || (opc == `EXEC_OPC_JAL) || (opc == `EXEC_OPC_JALR)
            || (opc == `EXEC_OPC_BRANCH) || (opc == `EXEC_OPC_LOAD)
            || (opc == `EXEC_OPC_STORE);
    endfunction

    // RV32I integer operation with alt selecting SUB and SRA
    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b, input logic [4:0] sh);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [4:0] fault_cause_of(input logic is_load, input mem_resp_e resp);
        case (resp)
            RESP_MISALIGNED: return is_load ? `EXEC_CAUSE_LOAD_MISALIGNED
                                            : `EXEC_CAUSE_STORE_MISALIGNED;
            RESP_ACCESS: return is_load ? `EXEC_CAUSE_LOAD_ACCESS : `EXEC_CAUSE_STORE_ACCESS;
            default: return is_load ? `EXEC_CAUSE_LOAD_PAGE : `EXEC_CAUSE_STORE_PAGE;
        endcase
    endfunction

    // Random fields with the opcode and a few fields forced per class
    function automatic word_t make_instr();
        word_t w;
        word_t r;
        w = next_rand();
        r = next_rand();
        case (r % 10)
            0: begin
                w[6:0]   = `EXEC_OPC_OP;
                w[31:25] = (r[7:4] < 10) ? 7'h00 : (r[7:4] < 14) ? 7'h20 : w[31:25];
            end
            1: begin
                w[6:0]   = `EXEC_OPC_OP_IMM;
                w[31:25] = (r[7:4] < 8) ? 7'h00 : (r[7:4] < 13) ? 7'h20 : w[31:25];
            end
            2: w[6:0] = `EXEC_OPC_LUI;
            3: w[6:0] = `EXEC_OPC_AUIPC;
            4: w[6:0] = `EXEC_OPC_JAL;
            5: begin
                w[6:0] = `EXEC_OPC_JALR;
                if (r[7:4] != 4'd0) begin
                    w[14:12] = 3'd0;
                end
            end
            6: w[6:0] = `EXEC_OPC_BRANCH;
            7: w[6:0] = `EXEC_OPC_LOAD;
            8: begin
                w[6:0] = `EXEC_OPC_STORE;
                if (r[7:4] != 4'd0) begin
                    w[14] = 1'b0;
                end
            end
            default: begin
                w[6:0] = r[14:8];
                while (known_opcode(w[6:0])) begin
                    w[6:0] = w[6:0] + 7'd1;
                end
            end
        endcase
        return w;
    endfunction

    // Expected outputs in the cycle an instruction is first presented
    task automatic predict(input word_t w, input word_t pc, input word_t a, input word_t b,
                           output expect_t e);
        logic [2:0] f3;
        logic [6:0] f7;
        logic       legal;
        logic       writes;
        logic       shift;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_u;
        word_t      imm_j;
        f3     = w[14:12];
        f7     = w[31:25];
        shift  = (f3 == 3'd1) || (f3 == 3'd5);
        imm_i  = {{20{w[31]}}, w[31:20]};
        imm_s  = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u  = {w[31:12], 12'h000};
        imm_j  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        e      = '0;
        e.ready = 1'b1;
        e.rs1   = w[19:15];
        e.rs2   = w[24:20];
        e.rd    = w[11:7];
        legal  = 1'b1;
        writes = 1'b0;
        case (w[6:0])
            `EXEC_OPC_OP: begin
                legal   = ((f7 & 7'h5F) == 7'd0) && (!f7[5] || f3 == 3'd0 || f3 == 3'd5);
                writes  = 1'b1;
                e.wdata = alu_model(f3, f7[5], a, b, b[4:0]);
            end
            `EXEC_OPC_OP_IMM: begin
                legal   = !shift || (((f7 & 7'h5F) == 7'd0) && !(f3 == 3'd1 && f7[5]));
                writes  = 1'b1;
                e.wdata = alu_model(f3, (f3 == 3'd5) && f7[5], a, imm_i, w[24:20]);
            end
            `EXEC_OPC_LUI: begin
                writes  = 1'b1;
                e.wdata = imm_u;
            end
            `EXEC_OPC_AUIPC: begin
                writes  = 1'b1;
                e.wdata = pc + imm_u;
            end
            `EXEC_OPC_JAL: begin
                writes       = 1'b1;
                e.wdata      = pc + 32'd4;
                e.taken      = 1'b1;
                e.chk_target = 1'b1;
                e.target     = pc + imm_j;
            end
            `EXEC_OPC_JALR: begin
                legal        = (f3 == 3'd0);
                writes       = 1'b1;
                e.wdata      = pc + 32'd4;
                e.taken      = legal;
                e.chk_target = legal;
                e.target     = a + imm_i;
            end
            `EXEC_OPC_BRANCH: begin
                legal        = (f3 != 3'd2) && (f3 != 3'd3);
                e.taken      = legal && branch_model(f3, a, b);
                e.chk_target = legal;
                e.target     = pc + imm_b;
            end
            `EXEC_OPC_LOAD: begin
                e.ready = 1'b0;
                e.cmd   = MEM_LOAD;
                e.addr  = a + imm_i;
                e.f3    = f3;
            end
            `EXEC_OPC_STORE: begin
                legal = !f3[2];
                if (legal) begin
                    e.ready = 1'b0;
                    e.cmd   = MEM_STORE;
                    e.addr  = a + imm_s;
                    e.f3    = f3;
                    e.sdata = b;
                end
            end
            default: legal = 1'b0;
        endcase
        e.exc   = !legal;
        e.cause = `EXEC_CAUSE_ILLEGAL;
        e.wr    = writes && legal && (w[11:7] != 5'd0);
    endtask

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        assert (act === exp) else begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, act, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (checking) begin
            check_value("rs1_addr", rs1_addr, expected.rs1);
            check_value("rs2_addr", rs2_addr, expected.rs2);
            check_value("rd_addr", rd_addr, expected.rd);
            check_value("fetch_out.ready", fetch_out.ready, expected.ready);
            check_value("fetch_out.exc_start", fetch_out.exc_start, expected.exc);
            if (expected.exc) begin
                check_value("fetch_out.exc_cause", fetch_out.exc_cause, expected.cause);
            end
            check_value("rd_write", rd_write, expected.wr);
            if (expected.wr) begin
                check_value("rd_wdata", rd_wdata, expected.wdata);
            end
            check_value("fetch_out.branch_taken", fetch_out.branch_taken, expected.taken);
            if (expected.chk_target) begin
                check_value("fetch_out.branch_target", fetch_out.branch_target,
                            expected.target);
            end
            check_value("mem_req.cmd", mem_req.cmd, expected.cmd);
            if (expected.cmd != MEM_NONE) begin
                check_value("mem_req.addr", mem_req.addr, expected.addr);
            end
            if (expected.cmd == MEM_LOAD) begin
                check_value("mem_req.load_type", mem_req.load_type, expected.f3);
            end
            if (expected.cmd == MEM_STORE) begin
                check_value("mem_req.store_type", mem_req.store_type, expected.f3[1:0]);
                check_value("mem_req.store_data", mem_req.store_data, expected.sdata);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: instruction stream not finished after %0d cycles", cycle_count);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    // One instruction plus the memory model for loads and stores
    task automatic run_instr();
        word_t     w;
        word_t     pc;
        word_t     a;
        word_t     b;
        expect_t   e;
        int        delay;
        logic      is_load;
        mem_resp_e resp;
        w  = make_instr();
        pc = next_rand() & 32'hFFFF_FFFC;
        a  = next_rand();
        b  = next_rand();
        if (next_rand() % 4 == 0) begin
            b = a;
        end
        delay = next_rand() % 5;
        predict(w, pc, a, b, e);
        @(posedge clk);
        fetch_in          <= {w, pc};
        rs1_data          <= a;
        rs2_data          <= b;
        mem_rsp.resp      <= RESP_IDLE;
        mem_rsp.load_data <= '0;
        expected = e;
        checking = 1'b1;
        if (e.cmd != MEM_NONE) begin
            is_load = (e.cmd == MEM_LOAD);
            repeat (delay) @(posedge clk);
            @(posedge clk);
            // Address bit 9 selects a fault and bits 11:10 its kind
            if (!e.addr[9]) begin
                resp = RESP_DONE;
            end else if (e.addr[11:10] == 2'd0) begin
                resp = RESP_MISALIGNED;
            end else if (e.addr[11:10] == 2'd1) begin
                resp = RESP_ACCESS;
            end else begin
                resp = RESP_PAGE;
            end
            mem_rsp.resp      <= resp;
            mem_rsp.load_data <= e.addr ^ 32'h5A5A_0000;
            e.cmd = MEM_NONE;
            if (resp == RESP_DONE) begin
                e.ready  = 1'b1;
                e.wr     = is_load && (w[11:7] != 5'd0);
                e.wdata  = e.addr ^ 32'h5A5A_0000;
                expected = e;
            end else begin
                expected = e;
                @(posedge clk);
                mem_rsp.resp <= RESP_IDLE;
                e.ready  = 1'b1;
                e.exc    = 1'b1;
                e.cause  = fault_cause_of(is_load, resp);
                expected = e;
            end
        end
    endtask

    initial begin
        checking = 1'b0;
        expected = '0;
        // ADDI x0, x0, 0 during reset
        fetch_in          <= {32'h0000_0013, 32'h0000_0000};
        rs1_data          <= '0;
        rs2_data          <= '0;
        mem_rsp.resp      <= RESP_IDLE;
        mem_rsp.load_data <= '0;
        wait (rst_n === 1'b1);
        for (int n = 0; n < N_INSTR; n++) begin
            run_instr();
        end
        @(posedge clk);
        checking = 1'b0;
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* exec_stage.f */
+incdir+hw
hw/exec_pkg.sv
hw/exec_decoder.sv
hw/exec_alu.sv
hw/exec_branch_cond.sv
hw/exec_mem_seq.sv
hw/exec_stage.sv
testbench/tb_clock.sv
testbench/tb_exec_stage.sv
